// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := ex_unit_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
hw/ex_types_pkg.sv
hw/ex_isa_pkg.sv
hw/ex_operand_stage.sv
hw/ex_alu_stage.sv
hw/ex_unit.sv
tests/ex_unit_sva.sv
tests/ex_unit_tb.sv

// File: hw/ex_alu_stage.sv
`timescale 1ns/1ps

module ex_alu_stage
    import ex_types_pkg::*;
    import ex_isa_pkg::*;
(
    input  logic    iw_clk,
    input  logic    iw_rst,
    input  logic    flush,
    input  logic    stall,
    input  addr_t   op_pc,
    input  opc_t    op_opc,
    input  data_t   op_a,
    input  data_t   op_b,
    input  logic    op_cond,
    input  gp_idx_t op_tgt_gp,
    input  logic    op_gp_we,
    output data_t   wb_result,
    output gp_idx_t wb_tgt_gp,
    output logic    wb_gp_we,
    output flags_t  wb_flags,
    output logic    wb_flags_we,
    output logic    branch_taken,
    output addr_t   branch_pc
);

    // Extra top bit holds carry out or borrow
    logic [data_w:0] sum;
    logic [data_w:0] diff;
    logic [data_w:0] shl_ext;
    logic [data_w:0] shr_ext;
    logic            add_v;
    logic            sub_v;
    shamt_t          n;

    data_t  res;
    flags_t fl;
    logic   fl_we;
    logic   br_taken;
    addr_t  br_pc;

    assign sum  = {1'b0, op_a} + {1'b0, op_b};
    assign diff = {1'b0, op_a} - {1'b0, op_b};

    // Two's-complement overflow from the operand and result signs
    assign add_v = (op_a[data_w-1] == op_b[data_w-1]) && (sum[data_w-1] != op_a[data_w-1]);
    assign sub_v = (op_a[data_w-1] != op_b[data_w-1]) && (diff[data_w-1] != op_a[data_w-1]);

    // The spare bit catches the last bit shifted out
    assign n       = op_b[shamt_w-1:0];
    assign shl_ext = {1'b0, op_a} << n;
    assign shr_ext = {op_a, 1'b0} >> n;

    always_comb begin
        res      = '0;
        fl       = '0;
        fl_we    = 1'b0;
        br_taken = 1'b0;
        br_pc    = '0;
        case (op_opc)
            OPC_MOVur, OPC_MOVui: begin
                res        = op_b;
                fl[flag_z] = (op_b == '0);
                fl_we      = 1'b1;
            end
            OPC_ADDur, OPC_ADDui: begin
                res        = sum[data_w-1:0];
                fl[flag_z] = (sum[data_w-1:0] == '0);
                fl[flag_c] = sum[data_w];
                fl_we      = 1'b1;
            end
            OPC_SUBur: begin
                res        = diff[data_w-1:0];
                fl[flag_z] = (diff[data_w-1:0] == '0);
                fl[flag_c] = diff[data_w];
                fl_we      = 1'b1;
            end
            // Both unsigned compares set C when a is below b
            OPC_CMPur, OPC_CMPui: begin
                fl[flag_z] = (diff[data_w-1:0] == '0);
                fl[flag_c] = diff[data_w];
                fl_we      = 1'b1;
            end
            OPC_ANDur, OPC_ORur, OPC_XORur: begin
                if (op_opc == OPC_ANDur) begin
                    res = op_a & op_b;
                end else if (op_opc == OPC_ORur) begin
                    res = op_a | op_b;
                end else begin
                    res = op_a ^ op_b;
                end
                fl[flag_z] = (res == '0);
                fl_we      = 1'b1;
            end
            OPC_ADDsr, OPC_ADDsi: begin
                res        = sum[data_w-1:0];
                fl[flag_z] = (sum[data_w-1:0] == '0);
                fl[flag_n] = sum[data_w-1];
                fl[flag_v] = add_v;
                fl_we      = 1'b1;
            end
            OPC_SUBsr, OPC_CMPsr: begin
                if (op_opc == OPC_SUBsr) begin
                    res = diff[data_w-1:0];
                end
                fl[flag_z] = (diff[data_w-1:0] == '0);
                fl[flag_n] = diff[data_w-1];
                fl[flag_v] = sub_v;
                fl_we      = 1'b1;
            end
            OPC_MOVsi: begin
                res        = op_b;
                fl[flag_z] = (op_b == '0);
                fl[flag_n] = op_b[data_w-1];
                fl_we      = 1'b1;
            end
            OPC_SHLur, OPC_SHRur: begin
                if (n == '0) begin
                    // Zero shift leaves a and the flags alone
                    res = op_a;
                end else if (n >= data_w) begin
                    fl[flag_z] = 1'b1;
                    fl_we      = 1'b1;
                end else begin
                    if (op_opc == OPC_SHLur) begin
                        res        = shl_ext[data_w-1:0];
                        fl[flag_c] = shl_ext[data_w];
                    end else begin
                        res        = shr_ext[data_w:1];
                        fl[flag_c] = shr_ext[0];
                    end
                    fl[flag_z] = (res == '0);
                    fl_we      = 1'b1;
                end
            end
            OPC_MCCur: begin
                if (op_cond) begin
                    res        = op_b;
                    fl[flag_z] = (op_b == '0);
                    fl_we      = 1'b1;
                end else begin
                    res = op_a;
                end
            end
            OPC_BCCso: begin
                br_taken = op_cond;
                if (op_cond) begin
                    br_pc = op_pc + {{(addr_w - data_w){op_b[data_w-1]}}, op_b};
                end
            end
            default: begin
                // NOP and LUI produce an empty slot here
                res = '0;
            end
        endcase
    end

    // Output register bank, flush beats stall
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst || flush) begin
            wb_result    <= '0;
            wb_tgt_gp    <= '0;
            wb_gp_we     <= 1'b0;
            wb_flags     <= '0;
            wb_flags_we  <= 1'b0;
            branch_taken <= 1'b0;
            branch_pc    <= '0;
        end else if (!stall) begin
            wb_result    <= res;
            wb_tgt_gp    <= op_tgt_gp;
            wb_gp_we     <= op_gp_we;
            wb_flags     <= fl;
            wb_flags_we  <= fl_we;
            branch_taken <= br_taken;
            branch_pc    <= br_pc;
        end
    end

endmodule

// File: hw/ex_isa_pkg.sv
package ex_isa_pkg;

    // Opcodes handled by the execute stage, NOP means an empty slot
    typedef enum logic [7:0] {
        OPC_NOP   = 8'h00,
        // Unsigned register forms
        OPC_MOVur = 8'h01,
        OPC_ADDur = 8'h02,
        OPC_SUBur = 8'h03,
        OPC_ANDur = 8'h04,
        OPC_ORur  = 8'h05,
        OPC_XORur = 8'h06,
        OPC_SHLur = 8'h07,
        OPC_SHRur = 8'h08,
        OPC_CMPur = 8'h09,
        OPC_MCCur = 8'h0a,
        // Signed register forms
        OPC_ADDsr = 8'h10,
        OPC_SUBsr = 8'h11,
        OPC_CMPsr = 8'h12,
        // Unsigned immediate forms, upper bits from the LUI register
        OPC_MOVui = 8'h20,
        OPC_ADDui = 8'h21,
        OPC_CMPui = 8'h22,
        OPC_LUIui = 8'h23,
        // Signed immediate forms
        OPC_MOVsi = 8'h30,
        OPC_ADDsi = 8'h31,
        // PC-relative conditional branch
        OPC_BCCso = 8'h40
    } opc_t;

    // Condition codes, any unlisted encoding evaluates false
    typedef enum logic [3:0] {
        CC_RA = 4'h0,
        CC_EQ = 4'h1,
        CC_NE = 4'h2,
        CC_LT = 4'h3,
        CC_GT = 4'h4,
        CC_GE = 4'h5,
        CC_LE = 4'h6,
        CC_BT = 4'h7,
        CC_AT = 4'h8,
        CC_BE = 4'h9,
        CC_AE = 4'ha
    } cc_t;

    typedef logic [3:0] flags_t;

    // Bit positions inside flags_t
    localparam int flag_z = 0;
    localparam int flag_n = 1;
    localparam int flag_c = 2;
    localparam int flag_v = 3;

endpackage

// File: hw/ex_operand_stage.sv
`timescale 1ns/1ps

module ex_operand_stage
    import ex_types_pkg::*;
    import ex_isa_pkg::*;
(
    input  logic    iw_clk,
    input  logic    iw_rst,
    input  logic    flush,
    input  logic    stall,
    input  addr_t   pc,
    input  opc_t    opc,
    input  cc_t     cc,
    input  imm12_t  imm12,
    input  data_t   src_val,
    input  data_t   tgt_val,
    input  gp_idx_t tgt_gp,
    input  logic    tgt_gp_we,
    input  flags_t  flags_in,
    output addr_t   op_pc,
    output opc_t    op_opc,
    output data_t   op_a,
    output data_t   op_b,
    output logic    op_cond,
    output gp_idx_t op_tgt_gp,
    output logic    op_gp_we
);

    // Upper immediate, bank 0 only
    imm12_t uimm;
    data_t  b_sel;
    logic   cond;

    // Evaluate one condition code against a flag word
    function automatic logic cond_true(input cc_t c, input flags_t f);
        logic z;
        logic n;
        logic cy;
        logic v;
        logic t;
        z  = f[flag_z];
        n  = f[flag_n];
        cy = f[flag_c];
        v  = f[flag_v];
        case (c)
            CC_RA:   t = 1'b1;
            CC_EQ:   t = z;
            CC_NE:   t = !z;
            CC_LT:   t = n ^ v;
            CC_GT:   t = !z && !(n ^ v);
            CC_GE:   t = !(n ^ v);
            CC_LE:   t = z || (n ^ v);
            CC_BT:   t = cy;
            CC_AT:   t = !cy && !z;
            CC_BE:   t = cy || z;
            CC_AE:   t = !cy;
            default: t = 1'b0;
        endcase
        return t;
    endfunction

    // LUI takes effect at this edge so the next instruction sees it
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            uimm <= '0;
        end else if (flush) begin
            uimm <= '0;
        end else if (!stall && opc == OPC_LUIui) begin
            uimm <= imm12;
        end
    end

    // Second operand by opcode class
    always_comb begin
        case (opc)
            OPC_MOVur, OPC_ADDur, OPC_SUBur, OPC_ANDur, OPC_ORur, OPC_XORur,
            OPC_SHLur, OPC_SHRur, OPC_CMPur, OPC_MCCur,
            OPC_ADDsr, OPC_SUBsr, OPC_CMPsr: begin
                b_sel = src_val;
            end
            OPC_MOVui, OPC_ADDui, OPC_CMPui: begin
                b_sel = {uimm, imm12};
            end
            OPC_MOVsi, OPC_ADDsi, OPC_BCCso: begin
                b_sel = {{(data_w - imm_w){imm12[imm_w-1]}}, imm12};
            end
            default: begin
                b_sel = '0;
            end
        endcase
    end

    assign cond = cond_true(cc, flags_in);

    // Stage register, flush beats stall
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst || flush) begin
            op_pc     <= '0;
            op_opc    <= OPC_NOP;
            op_a      <= '0;
            op_b      <= '0;
            op_cond   <= 1'b0;
            op_tgt_gp <= '0;
            op_gp_we  <= 1'b0;
        end else if (!stall) begin
            op_pc     <= pc;
            op_opc    <= opc;
            op_a      <= tgt_val;
            op_b      <= b_sel;
            op_cond   <= cond;
            op_tgt_gp <= tgt_gp;
            op_gp_we  <= tgt_gp_we;
        end
    end

endmodule

// File: hw/ex_types_pkg.sv
package ex_types_pkg;

    // Datapath widths
    localparam int data_w = 24;
    localparam int addr_w = 48;

    // Instruction field widths
    localparam int imm_w    = 12;
    localparam int shamt_w  = 5;
    localparam int gp_idx_w = 4;

    // General register value
    typedef logic [data_w-1:0] data_t;

    // Program counter and branch target
    typedef logic [addr_w-1:0] addr_t;

    // Immediate field as it comes from decode
    typedef logic [imm_w-1:0] imm12_t;

    // Shift amount, taken from the low bits of operand b
    typedef logic [shamt_w-1:0] shamt_t;

    // General register index
    typedef logic [gp_idx_w-1:0] gp_idx_t;

endpackage

// File: hw/ex_unit.sv
`timescale 1ns/1ps

module ex_unit
    import ex_types_pkg::*;
    import ex_isa_pkg::*;
(
    input  logic    iw_clk,
    input  logic    iw_rst,
    input  logic    flush,
    input  logic    stall,
    input  addr_t   pc,
    input  opc_t    opc,
    input  cc_t     cc,
    input  imm12_t  imm12,
    input  data_t   src_val,
    input  data_t   tgt_val,
    input  gp_idx_t tgt_gp,
    input  logic    tgt_gp_we,
    input  flags_t  flags_in,
    output data_t   wb_result,
    output gp_idx_t wb_tgt_gp,
    output logic    wb_gp_we,
    output flags_t  wb_flags,
    output logic    wb_flags_we,
    output logic    branch_taken,
    output addr_t   branch_pc
);

    // Operand stage to ALU stage
    addr_t   op_pc;
    opc_t    op_opc;
    data_t   op_a;
    data_t   op_b;
    logic    op_cond;
    gp_idx_t op_tgt_gp;
    logic    op_gp_we;

    ex_operand_stage u_operand (
        .iw_clk    (iw_clk),
        .iw_rst    (iw_rst),
        .flush     (flush),
        .stall     (stall),
        .pc        (pc),
        .opc       (opc),
        .cc        (cc),
        .imm12     (imm12),
        .src_val   (src_val),
        .tgt_val   (tgt_val),
        .tgt_gp    (tgt_gp),
        .tgt_gp_we (tgt_gp_we),
        .flags_in  (flags_in),
        .op_pc     (op_pc),
        .op_opc    (op_opc),
        .op_a      (op_a),
        .op_b      (op_b),
        .op_cond   (op_cond),
        .op_tgt_gp (op_tgt_gp),
        .op_gp_we  (op_gp_we)
    );

    ex_alu_stage u_alu (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .flush        (flush),
        .stall        (stall),
        .op_pc        (op_pc),
        .op_opc       (op_opc),
        .op_a         (op_a),
        .op_b         (op_b),
        .op_cond      (op_cond),
        .op_tgt_gp    (op_tgt_gp),
        .op_gp_we     (op_gp_we),
        .wb_result    (wb_result),
        .wb_tgt_gp    (wb_tgt_gp),
        .wb_gp_we     (wb_gp_we),
        .wb_flags     (wb_flags),
        .wb_flags_we  (wb_flags_we),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc)
    );

endmodule

// File: tests/ex_unit_sva.sv
`timescale 1ns/1ps

module ex_unit_sva
    import ex_types_pkg::*;
    import ex_isa_pkg::*;
(
    input logic    iw_clk,
    input logic    iw_rst,
    input logic    flush,
    input logic    stall,
    input logic    tgt_gp_we,
    input data_t   wb_result,
    input gp_idx_t wb_tgt_gp,
    input logic    wb_gp_we,
    input flags_t  wb_flags,
    input logic    wb_flags_we,
    input logic    branch_taken,
    input addr_t   branch_pc
);

    // No strobe while reset is held
    assert property (@(posedge iw_clk) iw_rst |-> !wb_gp_we && !wb_flags_we && !branch_taken)
        else $error("strobe high during reset");

    // The slot cleared in stage one reaches the outputs one edge later
    assert property (@(posedge iw_clk) disable iff (iw_rst)
        flush ##1 !stall |=> !wb_gp_we && !wb_flags_we && !branch_taken)
        else $error("strobe high two edges after flush");

    // Stall freezes the output bank
    assert property (@(posedge iw_clk) disable iff (iw_rst)
        stall && !flush |=> $stable(wb_result) && $stable(wb_tgt_gp) && $stable(wb_gp_we)
            && $stable(wb_flags) && $stable(wb_flags_we) && $stable(branch_taken)
            && $stable(branch_pc))
        else $error("output changed under stall");

    // A write strobe taken in at one edge leaves two edges later
    assert property (@(posedge iw_clk) disable iff (iw_rst)
        !iw_rst && !stall && !flush ##1 !stall && !flush |=> wb_gp_we == $past(tgt_gp_we, 2))
        else $error("register write strobe not delivered two edges after issue");

endmodule

bind ex_unit ex_unit_sva sva0 (.*);

// File: tests/ex_unit_tb.sv
`timescale 1ns/1ps

module ex_unit_tb
    import ex_types_pkg::*;
    import ex_isa_pkg::*;
();

    // Unsigned, signed, shift, LUI, flush, condition and stall groups
    localparam int n_instr = 4 * 10 + 4 * 5 + 2 * 4 + 3 + 1 + 2 * 12 + 1;

    // One expected writeback slot due when the unstalled edge count reaches due
    typedef struct {
        int      due;
        string   name;
        data_t   res;
        logic    res_chk;
        flags_t  fl;
        logic    fl_we;
        logic    gp_we;
        gp_idx_t gp;
        logic    br;
        addr_t   br_pc;
    } exp_t;

    logic    iw_clk;
    logic    iw_rst;
    logic    flush;
    logic    stall;
    addr_t   pc;
    opc_t    opc;
    cc_t     cc;
    imm12_t  imm12;
    data_t   src_val;
    data_t   tgt_val;
    gp_idx_t tgt_gp;
    logic    tgt_gp_we;
    flags_t  flags_in;
    data_t   wb_result;
    gp_idx_t wb_tgt_gp;
    logic    wb_gp_we;
    flags_t  wb_flags;
    logic    wb_flags_we;
    logic    branch_taken;
    addr_t   branch_pc;

    exp_t   pend[$];
    int     cyc = 0;
    int     errors = 0;
    int     checks = 0;
    imm12_t uimm_m = '0;

    ex_unit dut0 (.*);

    initial begin
        iw_clk = 1'b0;
        forever #50 iw_clk = ~iw_clk;
    end

    // Counts only edges where the pipeline advances
    always @(posedge iw_clk) begin
        if (!stall) cyc <= cyc + 1;
    end

    function automatic logic cc_holds(input cc_t c, input flags_t f);
        logic z;
        logic lt;
        logic cy;
        z  = f[flag_z];
        lt = f[flag_n] != f[flag_v];
        cy = f[flag_c];
        case (c)
            CC_RA: return 1'b1;
            CC_EQ: return z;
            CC_NE: return !z;
            CC_LT: return lt;
            CC_GT: return !(z || lt);
            CC_GE: return !lt;
            CC_LE: return z || lt;
            CC_BT: return cy;
            CC_AT: return !(cy || z);
            CC_BE: return cy || z;
            CC_AE: return !cy;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_value(input string nm, input string what,
                               input logic [47:0] exp, input logic [47:0] act);
        assert (exp === act) else begin
            $display("Fail %s %s expected %h actual %h", nm, what, exp, act);
            errors++;
        end
    endtask

    // Predict the slot from the rules, then present the instruction
    task automatic issue(input opc_t o, input cc_t c, input imm12_t im,
                         input data_t s, input data_t t, input string nm);
        exp_t   e;
        data_t  b;
        flags_t f;
        addr_t  pcv;
        logic   cnd;
        longint r;
        int     n;
        f = flags_t'($urandom);
        pcv = addr_t'({$urandom, $urandom});
        cnd = cc_holds(c, f);
        if (o inside {OPC_MOVui, OPC_ADDui, OPC_CMPui}) b = {uimm_m, im};
        else if (o inside {OPC_MOVsi, OPC_ADDsi, OPC_BCCso}) b = {{12{im[11]}}, im};
        else b = s;
        e = '{name: nm, res: '0, res_chk: 1'b1, fl: '0, fl_we: 1'b1,
              gp_we: 1'($urandom), gp: gp_idx_t'($urandom), br: 1'b0, br_pc: '0, due: 0};
        case (o)
            OPC_MOVur, OPC_MOVui: e.res = b;
            OPC_ADDur, OPC_ADDui: begin
                r = longint'(t) + longint'(b);
                e.res = r[23:0];
                e.fl[flag_c] = r > 64'hffffff;
            end
            OPC_SUBur, OPC_CMPur, OPC_CMPui: begin
                e.res = t - b;
                e.fl[flag_c] = t < b;
                e.res_chk = (o == OPC_SUBur);
            end
            OPC_ANDur: e.res = t & b;
            OPC_ORur:  e.res = t | b;
            OPC_XORur: e.res = t ^ b;
            OPC_ADDsr, OPC_ADDsi, OPC_SUBsr, OPC_CMPsr: begin
                if (o inside {OPC_ADDsr, OPC_ADDsi})
                    r = longint'($signed(t)) + longint'($signed(b));
                else
                    r = longint'($signed(t)) - longint'($signed(b));
                e.res = r[23:0];
                e.fl[flag_n] = e.res[23];
                e.fl[flag_v] = (r > 8388607) || (r < -8388608);
                e.res_chk = (o != OPC_CMPsr);
            end
            OPC_MOVsi: begin
                e.res = b;
                e.fl[flag_n] = b[23];
            end
            OPC_SHLur, OPC_SHRur: begin
                n = int'(b[4:0]);
                if (n == 0) begin
                    e.res = t;
                    e.fl_we = 1'b0;
                end else if (n >= 24) begin
                    e.res = '0;
                end else if (o == OPC_SHLur) begin
                    e.res = t << n;
                    e.fl[flag_c] = t[24-n];
                end else begin
                    e.res = t >> n;
                    e.fl[flag_c] = t[n-1];
                end
            end
            OPC_MCCur: begin
                e.res = cnd ? b : t;
                e.fl_we = cnd;
            end
            OPC_BCCso: begin
                e.res_chk = 1'b0;
                e.fl_we = 1'b0;
                e.br = cnd;
                if (cnd) e.br_pc = pcv + {{36{im[11]}}, im};
            end
            default: begin
                e.res_chk = 1'b0;
                e.fl_we = 1'b0;
            end
        endcase
        if (e.fl_we) e.fl[flag_z] = (e.res == '0);
        @(posedge iw_clk);
        opc <= o;
        cc <= c;
        imm12 <= im;
        src_val <= s;
        tgt_val <= t;
        flags_in <= f;
        pc <= pcv;
        tgt_gp <= e.gp;
        tgt_gp_we <= e.gp_we;
        flush <= 1'b0;
        stall <= 1'b0;
        e.due = cyc + 3;
        pend.push_back(e);
        if (o == OPC_LUIui) uimm_m = im;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge iw_clk);
            opc <= OPC_NOP;
            tgt_gp_we <= 1'b0;
            flush <= 1'b0;
            stall <= 1'b0;
        end
    endtask

    always @(negedge iw_clk) begin
        exp_t e;
        if (pend.size() > 0 && pend[0].due == cyc) begin
            e = pend.pop_front();
            checks++;
            if (e.res_chk) check_value(e.name, "result", e.res, wb_result);
            check_value(e.name, "flags_we", e.fl_we, wb_flags_we);
            if (e.fl_we) check_value(e.name, "flags", e.fl, wb_flags);
            check_value(e.name, "gp_we", e.gp_we, wb_gp_we);
            check_value(e.name, "tgt_gp", e.gp, wb_tgt_gp);
            check_value(e.name, "branch_taken", e.br, branch_taken);
            check_value(e.name, "branch_pc", e.br_pc, branch_pc);
        end
    end

    initial begin
        opc_t  uops[10];
        opc_t  sops[5];
        data_t s;
        data_t t;
        void'($urandom(32'h28c5c777));
        uops = '{OPC_MOVur, OPC_ADDur, OPC_SUBur, OPC_ANDur, OPC_ORur, OPC_XORur,
                 OPC_CMPur, OPC_MOVui, OPC_ADDui, OPC_CMPui};
        sops = '{OPC_ADDsr, OPC_SUBsr, OPC_CMPsr, OPC_ADDsi, OPC_MOVsi};
        iw_rst = 1'b1;
        flush = 1'b0;
        stall = 1'b0;
        pc = '0;
        // A live instruction with its strobes waits at the inputs during reset
        opc = OPC_ADDur;
        cc = CC_RA;
        imm12 = '0;
        src_val = '0;
        tgt_val = '0;
        tgt_gp = '0;
        tgt_gp_we = 1'b1;
        flags_in = '0;
        repeat (5) @(posedge iw_clk);
        iw_rst <= 1'b0;
        opc <= OPC_NOP;
        tgt_gp_we <= 1'b0;
        // Unsigned ops with zero, all ones and random operands
        for (int v = 0; v < 4; v++) begin
            for (int i = 0; i < 10; i++) begin
                t = (v == 0) ? 24'h0 : (v == 3) ? data_t'($urandom) : 24'hffffff;
                s = (v == 0) ? 24'h0 : (v == 1) ? 24'hffffff : (v == 2) ? 24'h1
                    : data_t'($urandom);
                issue(uops[i], CC_RA, (v == 1) ? 12'hfff : imm12_t'($urandom), s, t,
                      "unsigned");
            end
        end
        // Signed ops around the overflow boundary
        for (int v = 0; v < 4; v++) begin
            for (int i = 0; i < 5; i++) begin
                t = (v == 1) ? 24'h800000 : (v == 3) ? data_t'($urandom) : 24'h7fffff;
                s = (v == 0) ? 24'h1 : (v == 1) ? 24'hffffff : 24'h800000;
                issue(sops[i], CC_RA, v[0] ? 12'hfff : 12'h001, s, t, "signed");
            end
        end
        // Shifts with zero, in range and oversized amounts
        for (int i = 0; i < 2; i++) begin
            t = data_t'($urandom);
            issue(i ? OPC_SHRur : OPC_SHLur, CC_RA, '0, 24'd0, t, "shift");
            issue(i ? OPC_SHRur : OPC_SHLur, CC_RA, '0, data_t'(24'd1 + $urandom % 23), t,
                  "shift");
            issue(i ? OPC_SHRur : OPC_SHLur, CC_RA, '0, data_t'(24'd24 + $urandom % 8), t,
                  "shift");
            issue(i ? OPC_SHRur : OPC_SHLur, CC_RA, '0, 24'd23, 24'hffffff, "shift");
        end
        // Upper immediate followed by a flush that clears it
        issue(OPC_LUIui, CC_RA, 12'h800 | imm12_t'($urandom), '0, '0, "lui");
        issue(OPC_MOVui, CC_RA, imm12_t'($urandom), '0, '0, "lui_mov");
        issue(OPC_ADDui, CC_RA, imm12_t'($urandom), '0, data_t'($urandom), "lui_add");
        idle(3);
        @(posedge iw_clk);
        flush <= 1'b1;
        opc <= OPC_ADDur;
        tgt_gp_we <= 1'b1;
        uimm_m = '0;
        idle(1);
        issue(OPC_MOVui, CC_RA, 12'h9ab, '0, '0, "flush_mov");
        // Every condition code plus one undefined encoding
        for (int c = 0; c < 12; c++) begin
            issue(OPC_MCCur, cc_t'((c == 11) ? 15 : c), '0, data_t'($urandom),
                  data_t'($urandom), "mcc");
            issue(OPC_BCCso, cc_t'((c == 11) ? 15 : c), imm12_t'($urandom), '0, '0, "bcc");
        end
        // Stall with an instruction in each stage
        issue(OPC_ADDur, CC_RA, '0, data_t'($urandom), data_t'($urandom), "stall_add");
        @(posedge iw_clk);
        stall <= 1'b1;
        opc <= OPC_SUBur;
        tgt_gp_we <= 1'b1;
        repeat (2) @(posedge iw_clk);
        idle(5);
        if (pend.size() > 0) begin
            $display("Missing results: %0d expected slots never came due", pend.size());
            errors += pend.size();
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        #((n_instr + 20) * 100 * 2);
        $display("Timeout: the run did not reach its end in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
